/* hw/ppu_defs.svh */
`ifndef PPU_DEFS_SVH
`define PPU_DEFS_SVH

// Object and line limits
`define PPU_SPRITES         128
`define PPU_SLOTS           8
`define PPU_SPRITE_H        16     // Sprites are square
`define PPU_PALETTE_ENTRIES 8

// Data widths
`define PPU_COLOR_W         24
`define PPU_WORD_W          32
`define PPU_COORD_W         16     // One half of a coordinate word
`define PPU_TILE_W          7

// Memory address widths
`define PPU_OAM_AW          8
`define PPU_GFX_AW          11

`endif

/* hw/ppu_pkg.sv */
`include "ppu_defs.svh"

package ppu_pkg;

    // Odd OAM address, sprite position
    typedef struct packed {
        logic [`PPU_COORD_W-1:0] y;
        logic [`PPU_COORD_W-1:0] x;
    } oam_coord_t;

    // Even OAM address, sprite attributes
    typedef struct packed {
        logic                                 vflip;
        logic                                 hflip;
        logic [`PPU_WORD_W-`PPU_TILE_W-4:0]   unused;
        logic                                 palette;
        logic [`PPU_TILE_W-1:0]               tile;
    } oam_attr_t;

    typedef union packed {
        oam_coord_t coord;
        oam_attr_t  attr;
    } oam_word_t;

    // 4 * palette select + 2-bit pixel value
    typedef logic [$clog2(`PPU_PALETTE_ENTRIES)-1:0] pal_index_t;

endpackage

/* hw/oam_decoder.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module oam_decoder (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      vblank,
    output logic [$clog2(`PPU_PALETTE_ENTRIES)-1:0]   palette_addr,
    output logic [`PPU_OAM_AW-1:0]                    oam_addr,
    input  logic [`PPU_COLOR_W-1:0]                   palette_rdata,
    input  logic [`PPU_WORD_W-1:0]                    oam_rdata,
    input  logic [$clog2(`PPU_SPRITES)-1:0]           sprite_index,
    output logic [`PPU_COORD_W-1:0]                   sprite_x,
    output logic [`PPU_COORD_W-1:0]                   sprite_y,
    output logic [`PPU_TILE_W-1:0]                    sprite_tile,
    output logic                                      sprite_palette,
    output logic                                      sprite_vflip,
    output logic                                      sprite_hflip,
    input  ppu_pkg::pal_index_t                       pal_index,
    output logic [`PPU_COLOR_W-1:0]                   pal_color
);

    localparam int PAL_END   = `PPU_PALETTE_ENTRIES;            // Palette reads first
    localparam int ISSUE_END = PAL_END + 2 * `PPU_SPRITES;      // Then two OAM words per sprite
    localparam int LOAD_DONE = ISSUE_END + 2;                   // Last word lands two edges later

    logic [8:0]               load_ptr;  // Edges since vblank rose
    logic [8:0]               issue_oam;
    logic [8:0]               cap_ptr;   // Item whose data is on rdata now
    logic [8:0]               cap_oam;
    logic                     cap_valid;
    ppu_pkg::oam_word_t       oam_word;

    // Tables filled during vblank
    logic [`PPU_COLOR_W-1:0]  pal_table [`PPU_PALETTE_ENTRIES];
    logic [`PPU_COORD_W-1:0]  x_table [`PPU_SPRITES];
    logic [`PPU_COORD_W-1:0]  y_table [`PPU_SPRITES];
    logic [`PPU_TILE_W-1:0]   tile_table [`PPU_SPRITES];
    logic [`PPU_SPRITES-1:0]  pal_sel_table;
    logic [`PPU_SPRITES-1:0]  vflip_table;
    logic [`PPU_SPRITES-1:0]  hflip_table;

    assign issue_oam = load_ptr - 9'(PAL_END);
    assign cap_ptr   = load_ptr - 9'd2;
    assign cap_oam   = cap_ptr - 9'(PAL_END);
    assign cap_valid = (load_ptr >= 9'd2) && (load_ptr < 9'(LOAD_DONE));
    assign oam_word  = oam_rdata;

    // Read sequencer, one address per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr     <= '0;
            palette_addr <= '0;
            oam_addr     <= '0;
        end else if (!vblank) begin
            load_ptr     <= '0;
            palette_addr <= '0;
            oam_addr     <= '0;
        end else begin
            if (load_ptr != 9'(LOAD_DONE)) begin
                load_ptr <= load_ptr + 9'd1;
            end
            palette_addr <= (load_ptr < 9'(PAL_END)) ? load_ptr[2:0] : '0;
            if (load_ptr >= 9'(PAL_END) && load_ptr < 9'(ISSUE_END)) begin
                oam_addr <= issue_oam[`PPU_OAM_AW-1:0];
            end else begin
                oam_addr <= '0;
            end
        end
    end

    // Returned words go to the tables, OAM decoded by address parity
    always_ff @(posedge clk) begin
        if (vblank && cap_valid) begin
            if (cap_ptr < 9'(PAL_END)) begin
                pal_table[cap_ptr[2:0]] <= palette_rdata;
            end else if (cap_oam[0]) begin
                x_table[cap_oam[7:1]] <= oam_word.coord.x;
                y_table[cap_oam[7:1]] <= oam_word.coord.y;
            end else begin
                tile_table[cap_oam[7:1]]    <= oam_word.attr.tile;
                pal_sel_table[cap_oam[7:1]] <= oam_word.attr.palette;
                vflip_table[cap_oam[7:1]]   <= oam_word.attr.vflip;
                hflip_table[cap_oam[7:1]]   <= oam_word.attr.hflip;
            end
        end
    end

    // Lookups for the line evaluator
    assign sprite_x       = x_table[sprite_index];
    assign sprite_y       = y_table[sprite_index];
    assign sprite_tile    = tile_table[sprite_index];
    assign sprite_palette = pal_sel_table[sprite_index];
    assign sprite_vflip   = vflip_table[sprite_index];
    assign sprite_hflip   = hflip_table[sprite_index];

    assign pal_color = pal_table[pal_index];  // Palette lookup for the mixer

endmodule

/* hw/sprite_line_eval.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module sprite_line_eval (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              hsync,
    input  logic [9:0]                        vcount,
    output logic [$clog2(`PPU_SPRITES)-1:0]   sprite_index,
    input  logic [`PPU_COORD_W-1:0]           sprite_x,
    input  logic [`PPU_COORD_W-1:0]           sprite_y,
    input  logic [`PPU_TILE_W-1:0]            sprite_tile,
    input  logic                              sprite_palette,
    input  logic                              sprite_vflip,
    input  logic                              sprite_hflip,
    output logic [`PPU_GFX_AW-1:0]            gfx_addr,
    input  logic [`PPU_WORD_W-1:0]            gfx_rdata,
    output logic [`PPU_COORD_W-1:0]           slot_x [`PPU_SLOTS],
    output logic [`PPU_SLOTS-1:0]             slot_palette,
    output logic [`PPU_WORD_W-1:0]            slot_row [`PPU_SLOTS]
);

    localparam int SCAN_END  = `PPU_SPRITES;
    localparam int ISSUE_END = SCAN_END + `PPU_SLOTS;
    localparam int CAP_START = SCAN_END + 2;         // Read latency
    localparam int LINE_DONE = CAP_START + `PPU_SLOTS;

    logic [7:0]               line_ptr;   // Edges since hsync rose
    logic [3:0]               found;      // Slots filled on this line
    logic [7:0]               fetch_idx;
    logic [7:0]               cap_idx;
    logic                     scanning;
    logic                     issuing;
    logic                     capturing;
    logic [`PPU_COORD_W:0]    vpos;
    logic [`PPU_COORD_W:0]    y_top;
    logic [`PPU_COORD_W:0]    y_end;
    logic                     on_line;
    logic [3:0]               row_off;

    // Per-slot fetch info captured during the scan
    logic [`PPU_GFX_AW-1:0]   slot_addr [`PPU_SLOTS];
    logic [`PPU_SLOTS-1:0]    slot_hflip;

    // Pixel p moves to 15 - p
    function automatic logic [`PPU_WORD_W-1:0] mirror_row(input logic [`PPU_WORD_W-1:0] row);
        logic [`PPU_WORD_W-1:0] flipped;
        for (int p = 0; p < `PPU_SPRITE_H; p++) begin
            flipped[2*p +: 2] = row[2*(`PPU_SPRITE_H-1-p) +: 2];
        end
        return flipped;
    endfunction

    assign sprite_index = line_ptr[$clog2(`PPU_SPRITES)-1:0];
    assign fetch_idx    = line_ptr - 8'(SCAN_END);
    assign cap_idx      = line_ptr - 8'(CAP_START);
    assign scanning     = line_ptr < 8'(SCAN_END);
    assign issuing      = (line_ptr >= 8'(SCAN_END)) && (line_ptr < 8'(ISSUE_END));
    assign capturing    = (line_ptr >= 8'(CAP_START)) && (line_ptr < 8'(LINE_DONE));

    // Vertical cover test, one bit wider so y near the top of range cannot wrap
    assign vpos    = {7'd0, vcount};
    assign y_top   = {1'b0, sprite_y};
    assign y_end   = y_top + 17'(`PPU_SPRITE_H);
    assign on_line = (vpos >= y_top) && (vpos < y_end);

    // Only the low four bits of vcount - y matter once on_line holds
    assign row_off = vcount[3:0] - sprite_y[3:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            line_ptr <= '0;
            found    <= '0;
            gfx_addr <= '0;
        end else if (!hsync) begin
            line_ptr <= '0;
            found    <= '0;
            gfx_addr <= '0;
        end else begin
            if (line_ptr != 8'(LINE_DONE)) begin
                line_ptr <= line_ptr + 8'd1;
            end
            if (scanning && on_line && found < 4'(`PPU_SLOTS)) begin
                found <= found + 4'd1;
            end
            // Empty slots read address 0, their data is dropped anyway
            if (issuing && fetch_idx < {4'd0, found}) begin
                gfx_addr <= slot_addr[fetch_idx[2:0]];
            end else begin
                gfx_addr <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hsync && scanning && on_line && found < 4'(`PPU_SLOTS)) begin
            slot_x[found[2:0]]       <= sprite_x;
            slot_palette[found[2:0]] <= sprite_palette;
            slot_hflip[found[2:0]]   <= sprite_hflip;
            slot_addr[found[2:0]]    <= {sprite_tile, sprite_vflip ? ~row_off : row_off};
        end
        if (hsync && capturing) begin
            if (cap_idx < {4'd0, found}) begin
                slot_row[cap_idx[2:0]] <= slot_hflip[cap_idx[2:0]] ? mirror_row(gfx_rdata)
                                                                     : gfx_rdata;
            end else begin
                slot_row[cap_idx[2:0]] <= '0;  // Unused slot never hits
            end
        end
    end

endmodule

/* hw/pixel_mixer.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module pixel_mixer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [10:0]                hcount,
    input  logic [`PPU_COORD_W-1:0]    slot_x [`PPU_SLOTS],
    input  logic [`PPU_SLOTS-1:0]      slot_palette,
    input  logic [`PPU_WORD_W-1:0]     slot_row [`PPU_SLOTS],
    output ppu_pkg::pal_index_t        pal_index,
    input  logic [`PPU_COLOR_W-1:0]    pal_color,
    output logic [`PPU_COLOR_W-1:0]    pixel_color
);

    logic [9:0]               screen_x;
    logic [`PPU_COORD_W:0]    px;
    logic [`PPU_SLOTS-1:0]    hit;
    logic [3:0]               off [`PPU_SLOTS];
    logic [1:0]               pix [`PPU_SLOTS];

    assign screen_x = hcount[10:1];  // Each pixel spans two clocks
    assign px       = {7'd0, screen_x};

    // Horizontal hit test and pixel pick per slot
    always_comb begin
        for (int s = 0; s < `PPU_SLOTS; s++) begin
            hit[s] = ({1'b0, slot_x[s]} <= px) &&
                     (px < {1'b0, slot_x[s]} + 17'(`PPU_SPRITE_H));
            off[s] = screen_x[3:0] - slot_x[s][3:0];  // x - slot_x, valid on a hit
            pix[s] = hit[s] ? slot_row[s][2*off[s] +: 2] : 2'b00;
        end
    end

    // Walk from the highest slot down so the lowest opaque slot wins
    always_comb begin
        pal_index = '0;  // Backdrop
        for (int s = `PPU_SLOTS - 1; s >= 0; s--) begin
            if (pix[s] != 2'b00) begin
                pal_index = {slot_palette[s], pix[s]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_color <= '0;
        end else begin
            pixel_color <= pal_color;
        end
    end

endmodule

/* hw/ppu_top.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_top (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [10:0]                               hcount,
    input  logic [9:0]                                vcount,
    input  logic                                      vblank,
    input  logic                                      hsync,
    output logic [$clog2(`PPU_PALETTE_ENTRIES)-1:0]   palette_addr,
    output logic [`PPU_OAM_AW-1:0]                    oam_addr,
    output logic [`PPU_GFX_AW-1:0]                    gfx_addr,
    input  logic [`PPU_COLOR_W-1:0]                   palette_rdata,
    input  logic [`PPU_WORD_W-1:0]                    oam_rdata,
    input  logic [`PPU_WORD_W-1:0]                    gfx_rdata,
    output logic [`PPU_COLOR_W-1:0]                   pixel_color
);

    // Table lookup between decoder and line evaluator
    logic [$clog2(`PPU_SPRITES)-1:0]  sprite_index;
    logic [`PPU_COORD_W-1:0]          sprite_x;
    logic [`PPU_COORD_W-1:0]          sprite_y;
    logic [`PPU_TILE_W-1:0]           sprite_tile;
    logic                             sprite_palette;
    logic                             sprite_vflip;
    logic                             sprite_hflip;

    // Line slots
    logic [`PPU_COORD_W-1:0]          slot_x [`PPU_SLOTS];
    logic [`PPU_SLOTS-1:0]            slot_palette;
    logic [`PPU_WORD_W-1:0]           slot_row [`PPU_SLOTS];

    ppu_pkg::pal_index_t              pal_index;
    logic [`PPU_COLOR_W-1:0]          pal_color;

    oam_decoder u_decoder (
        .clk            (clk),
        .reset          (reset),
        .vblank         (vblank),
        .palette_addr   (palette_addr),
        .oam_addr       (oam_addr),
        .palette_rdata  (palette_rdata),
        .oam_rdata      (oam_rdata),
        .sprite_index   (sprite_index),
        .sprite_x       (sprite_x),
        .sprite_y       (sprite_y),
        .sprite_tile    (sprite_tile),
        .sprite_palette (sprite_palette),
        .sprite_vflip   (sprite_vflip),
        .sprite_hflip   (sprite_hflip),
        .pal_index      (pal_index),
        .pal_color      (pal_color)
    );

    sprite_line_eval u_line_eval (
        .clk            (clk),
        .reset          (reset),
        .hsync          (hsync),
        .vcount         (vcount),
        .sprite_index   (sprite_index),
        .sprite_x       (sprite_x),
        .sprite_y       (sprite_y),
        .sprite_tile    (sprite_tile),
        .sprite_palette (sprite_palette),
        .sprite_vflip   (sprite_vflip),
        .sprite_hflip   (sprite_hflip),
        .gfx_addr       (gfx_addr),
        .gfx_rdata      (gfx_rdata),
        .slot_x         (slot_x),
        .slot_palette   (slot_palette),
        .slot_row       (slot_row)
    );

    pixel_mixer u_mixer (
        .clk            (clk),
        .reset          (reset),
        .hcount         (hcount),
        .slot_x         (slot_x),
        .slot_palette   (slot_palette),
        .slot_row       (slot_row),
        .pal_index      (pal_index),
        .pal_color      (pal_color),
        .pixel_color    (pixel_color)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops a little after a rising edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module tb_mem_model (
    input  logic                      clk,
    input  logic [2:0]                palette_addr,
    input  logic [`PPU_OAM_AW-1:0]    oam_addr,
    input  logic [`PPU_GFX_AW-1:0]    gfx_addr,
    output logic [`PPU_COLOR_W-1:0]   palette_rdata,
    output logic [`PPU_WORD_W-1:0]    oam_rdata,
    output logic [`PPU_WORD_W-1:0]    gfx_rdata
);

    logic [`PPU_COLOR_W-1:0]  palette_mem [`PPU_PALETTE_ENTRIES];
    logic [`PPU_WORD_W-1:0]   oam_mem [2 * `PPU_SPRITES];
    logic [`PPU_WORD_W-1:0]   gfx_mem [1 << `PPU_GFX_AW];
    logic [`PPU_COLOR_W-1:0]  palette_q = '0;
    logic [`PPU_WORD_W-1:0]   oam_q = '0;
    logic [`PPU_WORD_W-1:0]   gfx_q = '0;

    // Fixed one-cycle read latency
    always @(posedge clk) begin
        palette_q <= palette_mem[palette_addr];
        oam_q     <= oam_mem[oam_addr];
        gfx_q     <= gfx_mem[gfx_addr];
    end

    assign palette_rdata = palette_q;
    assign oam_rdata     = oam_q;
    assign gfx_rdata     = gfx_q;

    // Sprites parked below the screen, other words tagged with their address
    task automatic fill_defaults();
        logic [10:0] a;
        for (int i = 0; i < (1 << `PPU_GFX_AW); i++) begin
            a = 11'(i);
            gfx_mem[a] = {a, ~a, a[9:0]};
        end
        for (int n = 0; n < `PPU_SPRITES; n++) begin
            set_sprite(n, n * 5, 512 + n, n, n[0], 1'b0, 1'b0);
        end
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            palette_mem[i[2:0]] = {8'(i), 8'(i * 3), 8'(i * 7)};
        end
    endtask

    task automatic set_sprite(input int n, input int x, input int y, input int tile,
                              input logic pal, input logic vflip, input logic hflip);
        oam_mem[8'(2 * n)]     = {vflip, hflip, 22'd0, pal, 7'(tile)};  // Attribute word
        oam_mem[8'(2 * n + 1)] = {16'(y), 16'(x)};                      // Coordinate word
    endtask

    task automatic set_palette(input int idx, input logic [`PPU_COLOR_W-1:0] color);
        palette_mem[3'(idx)] = color;
    endtask

    task automatic set_gfx_row(input int tile, input int row, input logic [31:0] data);
        gfx_mem[11'(tile * 16 + row)] = data;
    endtask

endmodule

/* verification/ppu_tb.sv */
`timescale 1ns/1ps
`include "ppu_defs.svh"

module ppu_tb;

    localparam int FRAME_CYCLES = 1 + 300 + 160 + 1281;  // Vblank, hsync, pixel sweep
    localparam int NUM_FRAMES   = 7;
    localparam int TIMEOUT      = (FRAME_CYCLES * NUM_FRAMES * 3) / 2;

    logic                      clk;
    logic                      reset;
    logic [10:0]               hcount;
    logic [9:0]                vcount;
    logic                      vblank;
    logic                      hsync;
    logic [2:0]                palette_addr;
    logic [`PPU_OAM_AW-1:0]    oam_addr;
    logic [`PPU_GFX_AW-1:0]    gfx_addr;
    logic [`PPU_COLOR_W-1:0]   palette_rdata;
    logic [`PPU_WORD_W-1:0]    oam_rdata;
    logic [`PPU_WORD_W-1:0]    gfx_rdata;
    logic [`PPU_COLOR_W-1:0]   pixel_color;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'hcb41_dbd7;

    // Slots expected on the line under test
    int                        ref_count;
    int                        ref_x [`PPU_SLOTS];
    logic                      ref_pal [`PPU_SLOTS];
    logic [`PPU_WORD_W-1:0]    ref_row [`PPU_SLOTS];

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) clk_gen0 (.clk(clk), .reset(reset));

    tb_mem_model mem0 (
        .clk(clk), .palette_addr(palette_addr), .oam_addr(oam_addr), .gfx_addr(gfx_addr),
        .palette_rdata(palette_rdata), .oam_rdata(oam_rdata), .gfx_rdata(gfx_rdata)
    );

    ppu_top dut0 (
        .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount), .vblank(vblank),
        .hsync(hsync), .palette_addr(palette_addr), .oam_addr(oam_addr), .gfx_addr(gfx_addr),
        .palette_rdata(palette_rdata), .oam_rdata(oam_rdata), .gfx_rdata(gfx_rdata),
        .pixel_color(pixel_color)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] reverse_pixels(input logic [31:0] row);
        logic [31:0] result;
        for (int p = 0; p < 16; p++) begin
            result[2*p +: 2] = row[30 - 2*p +: 2];  // Leftmost pixel becomes rightmost
        end
        return result;
    endfunction

    // First eight sprites in index order that cover the line
    task automatic build_line_ref(input int line);
        logic [31:0] attr;
        logic [31:0] coord;
        int          y;
        int          row;
        ref_count = 0;
        for (int n = 0; n < `PPU_SPRITES; n++) begin
            attr  = mem0.oam_mem[8'(2 * n)];
            coord = mem0.oam_mem[8'(2 * n + 1)];
            y     = int'(coord[31:16]);
            if (ref_count < `PPU_SLOTS && line >= y && line < y + 16) begin
                row = attr[31] ? 15 - (line - y) : line - y;  // Vertical flip
                ref_x[ref_count]   = int'(coord[15:0]);
                ref_pal[ref_count] = attr[7];
                ref_row[ref_count] = mem0.gfx_mem[11'(int'(attr[6:0]) * 16 + row)];
                if (attr[30]) begin
                    ref_row[ref_count] = reverse_pixels(ref_row[ref_count]);
                end
                ref_count++;
            end
        end
    endtask

    function automatic logic [23:0] expected_color(input int sx);
        logic [23:0] color;
        logic        found;
        int          p;
        color = mem0.palette_mem[0];  // Backdrop
        found = 1'b0;
        for (int s = 0; s < ref_count; s++) begin
            if (!found && sx >= ref_x[s] && sx < ref_x[s] + 16) begin
                p = int'(ref_row[s][2*(sx - ref_x[s]) +: 2]);
                if (p != 0) begin
                    color = mem0.palette_mem[3'(4 * int'(ref_pal[s]) + p)];
                    found = 1'b1;
                end
            end
        end
        return color;
    endfunction

    task automatic load_scene();
        mem0.fill_defaults();
        for (int i = 0; i < `PPU_PALETTE_ENTRIES; i++) begin
            mem0.set_palette(i, 24'(random_bits(24)));
        end
    endtask

    task automatic fill_tile(input int tile);
        for (int r = 0; r < 16; r++) begin
            mem0.set_gfx_row(tile, r, random_bits(32));
        end
    endtask

    // One vblank load, one line evaluation, then the whole visible line
    task automatic run_frame(input string name, input int line);
        build_line_ref(line);
        @(posedge clk);
        #2;
        vcount = 10'(line);
        vblank = 1'b1;
        repeat (300) @(posedge clk);
        #2;
        vblank = 1'b0;
        hsync  = 1'b1;
        repeat (160) @(posedge clk);
        #2;
        hsync = 1'b0;
        for (int h = 0; h <= 1280; h++) begin
            if (h > 0) begin  // Color of the previous hcount is now registered
                expect_equal($sformatf("%s x=%0d", name, (h - 1) / 2),
                             32'(expected_color((h - 1) / 2)), 32'(pixel_color));
            end
            if (h < 1280) begin
                hcount = 11'(h);
            end
            @(posedge clk);
            #2;
        end
        hcount = '0;
    endtask

    // Outputs as left by the last reset edge, then the loaders are released
    task automatic reset_state();
        wait (reset == 1'b0);
        expect_equal("reset pixel_color", 32'h0, 32'(pixel_color));
        expect_equal("reset palette_addr", 32'h0, 32'(palette_addr));
        expect_equal("reset oam_addr", 32'h0, 32'(oam_addr));
        expect_equal("reset gfx_addr", 32'h0, 32'(gfx_addr));
        vblank = 1'b0;
        hsync  = 1'b0;
    endtask

    task automatic backdrop_line();
        load_scene();
        run_frame("backdrop", 100);
    endtask

    task automatic single_sprite();
        load_scene();
        fill_tile(9);
        mem0.set_sprite(5, 37, 40, 9, 1'b1, 1'b0, 1'b0);
        run_frame("single top", 40);
        run_frame("single last row", 55);
        run_frame("single below", 56);
    endtask

    task automatic sprite_flips();
        load_scene();
        fill_tile(12);
        mem0.set_sprite(5, 300, 60, 12, 1'b1, 1'b1, 1'b0);
        run_frame("vflip", 63);
        mem0.set_sprite(5, 300, 60, 12, 1'b0, 1'b0, 1'b1);
        run_frame("hflip", 63);
    endtask

    // Ten sprites on line 200 where the last two sit apart and would show
    task automatic slot_limit();
        load_scene();
        for (int k = 0; k < 10; k++) begin
            fill_tile(20 + k);
            mem0.set_sprite(3 + 4 * k, (k < 8) ? 100 + 6 * k : 400 + 30 * (k - 8),
                            190 + k, 20 + k, k[0], 1'b0, 1'b0);
        end
        run_frame("slot limit", 200);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        hcount = '0;
        vcount = '0;
        vblank = 1'b1;  // Loaders run during reset
        hsync  = 1'b1;
        mem0.fill_defaults();
        reset_state();
        backdrop_line();
        single_sprite();
        sprite_flips();
        slot_limit();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hw
hw/ppu_pkg.sv
hw/oam_decoder.sv
hw/sprite_line_eval.sv
hw/pixel_mixer.sv
hw/ppu_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_model.sv
verification/ppu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= ppu_tb
RTL_TOP   ?= ppu_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= hw/ppu_pkg.sv hw/oam_decoder.sv hw/sprite_line_eval.sv hw/pixel_mixer.sv hw/ppu_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
